// File: design/executeStage.sv
`default_nettype none

module executeStage (
	execBus.execute ex,
	resultBus.execute rs
);
	import mipsPkg::*;

	logic [DataWidth-1:0] aluResult;

	always_comb begin
		aluResult = '0;
		case (ex.aluOp)
			AluAdd: aluResult = ex.operandA + ex.operandB; // Also LW/SW address
			AluSub: aluResult = ex.operandA - ex.operandB;
			AluAnd: aluResult = ex.operandA & ex.operandB;
			AluOr: aluResult = ex.operandA | ex.operandB;
			AluXor: aluResult = ex.operandA ^ ex.operandB;
			AluNor: aluResult = ~(ex.operandA | ex.operandB);
			AluSlt: begin
				aluResult[0] = $signed(ex.operandA) < $signed(ex.operandB);
			end
			AluSltu: begin
				aluResult[0] = ex.operandA < ex.operandB;
			end
			AluSll: aluResult = ex.operandB << ex.shamt;
			AluSrl: aluResult = ex.operandB >> ex.shamt;
			AluSra: aluResult = $signed(ex.operandB) >>> ex.shamt; // Sign fill
			AluLui: begin
				aluResult = {ex.operandB[ImmWidth-1:0], {(DataWidth-ImmWidth){1'b0}}};
			end
			default: aluResult = '0;
		endcase
	end

	assign rs.valid = ex.valid;
	assign rs.result = aluResult;
	assign rs.storeData = ex.storeData;
	assign rs.memRead = ex.memRead;
	assign rs.memWrite = ex.memWrite;
	assign rs.regWrite = ex.regWrite;
	assign rs.destReg = ex.destReg;

endmodule

`default_nettype wire

// File: design/instrDecoder.sv
`default_nettype none

module instrDecoder (
	input logic clk,
	input logic rstN,
	input logic instrValid,
	input mipsPkg::instrU instr,
	input logic [mipsPkg::DataWidth-1:0] rdDataA,
	input logic [mipsPkg::DataWidth-1:0] rdDataB,
	input logic wrEn,
	input logic [mipsPkg::RegAddrWidth-1:0] wrAddr,
	input logic [mipsPkg::DataWidth-1:0] wrData,
	output logic [mipsPkg::RegAddrWidth-1:0] rdAddrA,
	output logic [mipsPkg::RegAddrWidth-1:0] rdAddrB,
	execBus.decode ex
);
	import mipsPkg::*;

	logic [AluOpWidth-1:0] aluOp;
	logic useImm;
	logic sextImm;
	logic memRead;
	logic memWrite;
	logic regWrite;
	logic [RegAddrWidth-1:0] destReg;
	logic [DataWidth-1:0] regA;
	logic [DataWidth-1:0] regB;
	logic [DataWidth-1:0] immExt;

	assign rdAddrA = instr.r.rs;
	assign rdAddrB = instr.r.rt;

	// Bypass the write landing on this same edge
	assign regA = (wrEn && wrAddr == rdAddrA && rdAddrA != '0) ? wrData : rdDataA;
	assign regB = (wrEn && wrAddr == rdAddrB && rdAddrB != '0) ? wrData : rdDataB;

	assign immExt = sextImm ? {{(DataWidth-ImmWidth){instr.i.imm[ImmWidth-1]}}, instr.i.imm}
		: {{(DataWidth-ImmWidth){1'b0}}, instr.i.imm};

	always_comb begin
		aluOp = AluAdd;
		useImm = 1'b1;
		sextImm = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		regWrite = 1'b1;
		destReg = instr.i.rt; // I-type writes rt
		case (instr.i.opcode)
			OpSpecial: begin
				useImm = 1'b0;
				destReg = instr.r.rd;
				case (instr.r.funct)
					FnSll: aluOp = AluSll;
					FnSrl: aluOp = AluSrl;
					FnSra: aluOp = AluSra;
					FnAdd, FnAddu: aluOp = AluAdd; // No overflow trap
					FnSub, FnSubu: aluOp = AluSub;
					FnAnd: aluOp = AluAnd;
					FnOr: aluOp = AluOr;
					FnXor: aluOp = AluXor;
					FnNor: aluOp = AluNor;
					FnSlt: aluOp = AluSlt;
					FnSltu: aluOp = AluSltu;
					default: regWrite = 1'b0;
				endcase
			end
			OpAddi, OpAddiu: sextImm = 1'b1;
			OpSlti: begin
				aluOp = AluSlt;
				sextImm = 1'b1;
			end
			OpSltiu: begin
				aluOp = AluSltu;
				sextImm = 1'b1; // Sign extended, compared unsigned
			end
			OpAndi: aluOp = AluAnd;
			OpOri: aluOp = AluOr;
			OpXori: aluOp = AluXor;
			OpLui: aluOp = AluLui;
			OpLw: begin
				sextImm = 1'b1;
				memRead = 1'b1;
			end
			OpSw: begin
				sextImm = 1'b1;
				memWrite = 1'b1;
				regWrite = 1'b0;
			end
			default: regWrite = 1'b0; // Branches, jumps and the rest act as no-ops
		endcase
		if (destReg == '0) begin
			regWrite = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			ex.valid <= 1'b0;
		end else begin
			ex.valid <= instrValid;
		end
	end

	always_ff @(posedge clk) begin
		if (instrValid) begin
			ex.aluOp <= aluOp;
			ex.operandA <= regA;
			ex.operandB <= useImm ? immExt : regB;
			ex.shamt <= instr.r.shamt;
			ex.storeData <= regB;
			ex.memRead <= memRead;
			ex.memWrite <= memWrite;
			ex.regWrite <= regWrite;
			ex.destReg <= destReg;
		end
	end

endmodule

`default_nettype wire

// File: design/memoryWriteback.sv
`default_nettype none

module memoryWriteback (
	input logic clk,
	input logic rstN,
	resultBus.writeback rs,
	output logic wrEn,
	output logic [mipsPkg::RegAddrWidth-1:0] wrAddr,
	output logic [mipsPkg::DataWidth-1:0] wrData,
	output logic wbValid,
	output logic [mipsPkg::RegAddrWidth-1:0] wbReg,
	output logic [mipsPkg::DataWidth-1:0] wbData
);
	import mipsPkg::*;

	logic [DataWidth-1:0] dataMem [DataMemWords];
	logic [DataMemAddrWidth-1:0] memAddr;
	logic [DataWidth-1:0] loadData;

	assign memAddr = rs.result[DataMemAddrWidth+1:2]; // Word aligned
	assign loadData = dataMem[memAddr];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			dataMem <= '{default: '0};
		end else if (rs.valid && rs.memWrite) begin
			dataMem[memAddr] <= rs.storeData;
		end
	end

	// Register file write port, also the decoder's bypass source
	assign wrEn = rs.valid && rs.regWrite;
	assign wrAddr = rs.destReg;
	assign wrData = rs.memRead ? loadData : rs.result;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			wbValid <= 1'b0;
		end else begin
			wbValid <= wrEn;
		end
	end

	always_ff @(posedge clk) begin
		wbReg <= wrAddr; // Qualified by wbValid
		wbData <= wrData;
	end

endmodule

`default_nettype wire

// File: design/mipsCore.sv
`default_nettype none

module mipsCore (
	input logic clk,
	input logic rstN,
	input logic instrValid,
	input logic [mipsPkg::DataWidth-1:0] instr,
	output logic wbValid,
	output logic [mipsPkg::RegAddrWidth-1:0] wbReg,
	output logic [mipsPkg::DataWidth-1:0] wbData
);
	import mipsPkg::*;

	logic [RegAddrWidth-1:0] rdAddrA;
	logic [RegAddrWidth-1:0] rdAddrB;
	logic [DataWidth-1:0] rdDataA;
	logic [DataWidth-1:0] rdDataB;
	logic wrEn;
	logic [RegAddrWidth-1:0] wrAddr;
	logic [DataWidth-1:0] wrData;

	execBus exBus ();
	resultBus resBus ();

	instrDecoder i_decoder (
		.clk(clk),
		.rstN(rstN),
		.instrValid(instrValid),
		.instr(instr),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB),
		.wrEn(wrEn),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.rdAddrA(rdAddrA),
		.rdAddrB(rdAddrB),
		.ex(exBus.decode)
	);

	registerFile i_regFile (
		.clk(clk),
		.rstN(rstN),
		.rdAddrA(rdAddrA),
		.rdAddrB(rdAddrB),
		.wrEn(wrEn),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB)
	);

	executeStage i_execute (
		.ex(exBus.execute),
		.rs(resBus.execute)
	);

	memoryWriteback i_memWb (
		.clk(clk),
		.rstN(rstN),
		.rs(resBus.writeback),
		.wrEn(wrEn),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData)
	);

endmodule

`default_nettype wire

// File: design/mipsPkg.sv
`default_nettype none

package mipsPkg;

	localparam int DataWidth = 32;
	localparam int RegAddrWidth = 5;
	localparam int NumRegs = 32;
	localparam int DataMemWords = 64;
	localparam int DataMemAddrWidth = 6; // Word index, result bits 7:2
	localparam int ShamtWidth = 5;
	localparam int AluOpWidth = 4;
	localparam int ImmWidth = 16;

	// ALU op codes
	localparam logic [AluOpWidth-1:0] AluAnd = 4'd0;
	localparam logic [AluOpWidth-1:0] AluOr = 4'd1;
	localparam logic [AluOpWidth-1:0] AluAdd = 4'd2;
	localparam logic [AluOpWidth-1:0] AluNor = 4'd3;
	localparam logic [AluOpWidth-1:0] AluXor = 4'd4;
	localparam logic [AluOpWidth-1:0] AluSub = 4'd6;
	localparam logic [AluOpWidth-1:0] AluSlt = 4'd7;
	localparam logic [AluOpWidth-1:0] AluLui = 4'd8;
	localparam logic [AluOpWidth-1:0] AluSll = 4'd10;
	localparam logic [AluOpWidth-1:0] AluSrl = 4'd13;
	localparam logic [AluOpWidth-1:0] AluSltu = 4'd14;
	localparam logic [AluOpWidth-1:0] AluSra = 4'd15;

	localparam logic [5:0] OpSpecial = 6'd0;
	localparam logic [5:0] OpAddi = 6'd8;
	localparam logic [5:0] OpAddiu = 6'd9;
	localparam logic [5:0] OpSlti = 6'd10;
	localparam logic [5:0] OpSltiu = 6'd11;
	localparam logic [5:0] OpAndi = 6'd12;
	localparam logic [5:0] OpOri = 6'd13;
	localparam logic [5:0] OpXori = 6'd14;
	localparam logic [5:0] OpLui = 6'd15;
	localparam logic [5:0] OpLw = 6'd35;
	localparam logic [5:0] OpSw = 6'd43;

	// SPECIAL funct field
	localparam logic [5:0] FnSll = 6'd0;
	localparam logic [5:0] FnSrl = 6'd2;
	localparam logic [5:0] FnSra = 6'd3;
	localparam logic [5:0] FnAdd = 6'd32;
	localparam logic [5:0] FnAddu = 6'd33;
	localparam logic [5:0] FnSub = 6'd34;
	localparam logic [5:0] FnSubu = 6'd35;
	localparam logic [5:0] FnAnd = 6'd36;
	localparam logic [5:0] FnOr = 6'd37;
	localparam logic [5:0] FnXor = 6'd38;
	localparam logic [5:0] FnNor = 6'd39;
	localparam logic [5:0] FnSlt = 6'd42;
	localparam logic [5:0] FnSltu = 6'd43;

	typedef union packed {
		struct packed {
			logic [5:0] opcode;
			logic [RegAddrWidth-1:0] rs;
			logic [RegAddrWidth-1:0] rt;
			logic [RegAddrWidth-1:0] rd;
			logic [ShamtWidth-1:0] shamt;
			logic [5:0] funct;
		} r;
		struct packed {
			logic [5:0] opcode;
			logic [RegAddrWidth-1:0] rs;
			logic [RegAddrWidth-1:0] rt;
			logic [ImmWidth-1:0] imm;
		} i;
	} instrU;

endpackage

`default_nettype wire

// File: design/pipeBuses.sv
`default_nettype none

interface execBus;
	import mipsPkg::*;

	logic valid;
	logic [AluOpWidth-1:0] aluOp;
	logic [DataWidth-1:0] operandA;
	logic [DataWidth-1:0] operandB;
	logic [ShamtWidth-1:0] shamt;
	logic [DataWidth-1:0] storeData; // Forwarded rt value for SW
	logic memRead;
	logic memWrite;
	logic regWrite;
	logic [RegAddrWidth-1:0] destReg;

	modport decode (output valid, aluOp, operandA, operandB, shamt, storeData,
		memRead, memWrite, regWrite, destReg);
	modport execute (input valid, aluOp, operandA, operandB, shamt, storeData,
		memRead, memWrite, regWrite, destReg);
endinterface

interface resultBus;
	import mipsPkg::*;

	logic valid;
	logic [DataWidth-1:0] result; // ALU value or memory address
	logic [DataWidth-1:0] storeData;
	logic memRead;
	logic memWrite;
	logic regWrite;
	logic [RegAddrWidth-1:0] destReg;

	modport execute (output valid, result, storeData, memRead, memWrite, regWrite, destReg);
	modport writeback (input valid, result, storeData, memRead, memWrite, regWrite, destReg);
endinterface

`default_nettype wire

// File: design/registerFile.sv
`default_nettype none

module registerFile (
	input logic clk,
	input logic rstN,
	input logic [mipsPkg::RegAddrWidth-1:0] rdAddrA,
	input logic [mipsPkg::RegAddrWidth-1:0] rdAddrB,
	input logic wrEn,
	input logic [mipsPkg::RegAddrWidth-1:0] wrAddr,
	input logic [mipsPkg::DataWidth-1:0] wrData,
	output logic [mipsPkg::DataWidth-1:0] rdDataA,
	output logic [mipsPkg::DataWidth-1:0] rdDataB
);
	import mipsPkg::*;

	logic [DataWidth-1:0] regs [NumRegs];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			regs <= '{default: '0};
		end else if (wrEn && wrAddr != '0) begin // r0 stays zero
			regs[wrAddr] <= wrData;
		end
	end

	// Async reads, r0 forced to zero
	assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
	assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

`default_nettype wire

// File: dv/mipsCoreChecker.sv
`default_nettype none

module mipsCoreChecker (
	input logic clk,
	input logic rstN,
	input logic instrValid,
	input logic wbValid,
	input logic [mipsPkg::RegAddrWidth-1:0] wbReg
);
	timeunit 1ns;
	timeprecision 1ps;

	int violations = 0; // Read by the testbench

	// One edge into decode, one more into the report register
	reportFollowsStrobe: assert property (@(posedge clk) disable iff (!rstN)
		wbValid |-> $past(instrValid, 2))
	else begin
		violations++;
		$error("wbValid without an accepted instruction two edges earlier");
	end

	reportNotR0: assert property (@(posedge clk) disable iff (!rstN)
		wbValid |-> wbReg != '0)
	else begin
		violations++;
		$error("wbValid reported a write to register 0");
	end

	quietInReset: assert property (@(posedge clk) !rstN |=> !wbValid)
	else begin
		violations++;
		$error("wbValid high after a reset edge");
	end

endmodule

bind mipsCore mipsCoreChecker i_checker (
	.clk(clk),
	.rstN(rstN),
	.instrValid(instrValid),
	.wbValid(wbValid),
	.wbReg(wbReg)
);

`default_nettype wire

// File: dv/mipsCoreTb.sv
`default_nettype none

module mipsCoreTb;
	timeunit 1ns;
	timeprecision 1ps;
	import mipsPkg::*;

	logic clk = 1'b0;
	logic rstN;
	logic instrValid;
	logic [DataWidth-1:0] instr;
	logic wbValid;
	logic [RegAddrWidth-1:0] wbReg;
	logic [DataWidth-1:0] wbData;

	logic [DataWidth-1:0] vecInstr[$];
	logic [RegAddrWidth-1:0] vecDest[$];
	logic [DataWidth-1:0] vecData[$];
	bit vecChain[$]; // No idle gap before this one
	string vecName[$];

	// Scoreboard, oldest expectation first
	logic [RegAddrWidth-1:0] expRegQ[$];
	logic [DataWidth-1:0] expDataQ[$];
	string expNameQ[$];

	int mismatchCount = 0;
	int unexpectedCount = 0;
	int missingCount = 0;
	int fileErrors = 0;
	bit loaded = 1'b0;
	logic [31:0] rngState = 32'd44060;

	mipsCore i_dut (
		.clk(clk),
		.rstN(rstN),
		.instrValid(instrValid),
		.instr(instr),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData)
	);

	always #5 clk = ~clk;

	function automatic logic [31:0] nextRandom(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic readVectors();
		int fd;
		int fields;
		int chain;
		string line;
		string name;
		logic [31:0] word;
		logic [31:0] dest;
		logic [31:0] data;
		fd = $fopen("dv/mipsCoreVectors.txt", "r");
		if (fd == 0) begin
			$display("Cannot open dv/mipsCoreVectors.txt");
			fileErrors++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				fields = $sscanf(line, "%h %h %h %d %s", word, dest, data, chain, name);
				if (fields == 5) begin // Comment lines fail the scan
					vecInstr.push_back(word);
					vecDest.push_back(dest[RegAddrWidth-1:0]);
					vecData.push_back(data);
					vecChain.push_back(chain != 0);
					vecName.push_back(name);
				end
			end
			$fclose(fd);
			if (vecInstr.size() == 0) begin
				$display("Vector file holds no vectors");
				fileErrors++;
			end
		end
	endtask

	task automatic checkWriteback();
		logic [RegAddrWidth-1:0] expReg;
		logic [DataWidth-1:0] expData;
		string name;
		assert (expRegQ.size() > 0) else begin
			$display("Writeback to r%0d arrived with no instruction expecting one", wbReg);
			unexpectedCount++;
		end
		if (expRegQ.size() > 0) begin
			expReg = expRegQ.pop_front();
			expData = expDataQ.pop_front();
			name = expNameQ.pop_front();
			assert (wbReg == expReg) else begin
				$display("[FAIL] %s: wbReg expected %0d, actual %0d", name, expReg, wbReg);
				mismatchCount++;
			end
			assert (wbData == expData) else begin
				$display("[FAIL] %s: wbData expected 0x%08h, actual 0x%08h", name, expData,
					wbData);
				mismatchCount++;
			end
		end
	endtask

	always @(negedge clk) begin
		if (rstN && wbValid) begin
			checkWriteback();
		end
	end

	initial begin
		int gap;
		int checkerFails;
		int total;
		rstN = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		readVectors();
		loaded = 1'b1;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
		for (int i = 0; i < vecInstr.size(); i++) begin
			if (!vecChain[i]) begin
				rngState = nextRandom(rngState);
				gap = int'(rngState % 32'd3);
				repeat (gap) begin
					@(negedge clk);
					instrValid = 1'b0;
				end
			end
			@(negedge clk);
			instrValid = 1'b1;
			instr = vecInstr[i];
			if (vecDest[i] != '0) begin
				expRegQ.push_back(vecDest[i]);
				expDataQ.push_back(vecData[i]);
				expNameQ.push_back(vecName[i]);
			end
		end
		@(negedge clk);
		instrValid = 1'b0;
		repeat (4) @(negedge clk); // Last report drains
		missingCount = expRegQ.size();
		assert (missingCount == 0) else begin
			$display("%0d expected writebacks never arrived", missingCount);
		end
		checkerFails = i_dut.i_checker.violations;
		total = mismatchCount + unexpectedCount + missingCount + checkerFails + fileErrors;
		$display("Errors: %0d mismatched, %0d unexpected, %0d missing, %0d assertion, %0d file",
			mismatchCount, unexpectedCount, missingCount, checkerFails, fileErrors);
		if (total == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	initial begin
		int limit;
		wait (loaded);
		limit = vecInstr.size() * 3 + 50;
		repeat (limit) @(posedge clk);
		$display("Watchdog expired after %0d cycles", limit);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/mipsCoreVectors.txt
# Columns: instruction word, expected report register (00 = no report), expected data,
# chain (1 = issue on the edge right after the previous instruction), test name
34011234 01 00001234 0 ori
2402FFFB 02 FFFFFFFB 0 addiu_neg
3C03ABCD 03 ABCD0000 0 lui
34638001 03 ABCD8001 1 fwd_ori
3064F0F0 04 00008000 1 fwd_andi
38458000 05 FFFF7FFB 0 xori
28460001 06 00000001 0 slti
2C470001 07 00000000 0 sltiu
00224021 08 0000122F 0 addu
00234823 09 54329233 0 subu
00625024 0A ABCD8001 0 and
00245825 0B 00009234 0 or
00656026 0C 5432FFFA 0 xor
00246827 0D FFFF6DCB 0 nor
0041702A 0E 00000001 0 slt
0041782B 0F 00000000 0 sltu
00018100 10 00012340 0 sll
00038A02 11 00ABCD80 0 srl
00039203 12 FFABCD80 0 sra
24140064 14 00000064 0 addiu_src
0294A821 15 000000C8 1 fwd_addu
02A1B023 16 FFFFEE94 1 fwd_subu
AC030008 00 00000000 0 sw_low
AE820010 00 00000000 0 sw_high
8C180074 18 FFFFFFFB 1 lw_high
8C170008 17 ABCD8001 0 lw_low
8C190040 19 00000000 0 lw_unwritten
24200007 00 00000000 0 write_r0
0001D025 1A 00001234 1 read_r0
10210004 00 00000000 0 beq_noop
205CFFFD 1C FFFFFFF8 0 addi
0381E820 1D 0000122C 1 fwd_add

// File: mipsCore.f
design/mipsPkg.sv
design/pipeBuses.sv
design/registerFile.sv
design/instrDecoder.sv
design/executeStage.sv
design/memoryWriteback.sv
design/mipsCore.sv
dv/mipsCoreChecker.sv
dv/mipsCoreTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module mipsCoreTb -f mipsCore.f -o mipsCoreSim

./obj_dir/mipsCoreSim +verilator+error+limit+1000 | tee sim.log

if grep -qx '\*\*\* PASSED \*\*\*' sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
